/* legv8Core.f */
logic/legv8Pkg.sv
logic/stageReg.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/legv8Core.sv
tb/legv8CoreTb.sv

/* logic/decodeStage.sv */
`default_nettype none
`timescale 1ns/100ps

module decodeStage (
	input wire logic clk,
	input legv8Pkg::ifIdS ifId,
	input legv8Pkg::regAddrT exRd,
	input wire logic exMemRead,
	input wire logic wbValid,
	input legv8Pkg::regAddrT wbRd,
	input legv8Pkg::wordT wbData,
	output legv8Pkg::idExS idEx,
	output logic stall
);

	legv8Pkg::instrT instr;
	logic [10:0] opcode;
	legv8Pkg::regAddrT rd;
	legv8Pkg::regAddrT rn;
	legv8Pkg::regAddrT rm;
	legv8Pkg::regAddrT readAddr2;
	legv8Pkg::wordT readData1;
	legv8Pkg::wordT readData2;
	legv8Pkg::wordT imm;
	legv8Pkg::ctrlS ctrl;
	logic reg2Loc;

	assign instr = ifId.instr;
	assign opcode = instr[31:21];
	assign rd = instr[4:0];
	assign rn = instr[9:5];
	assign rm = instr[20:16];

	////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		reg2Loc = 1'b0;
		case (opcode)
			legv8Pkg::opAdd: begin
				ctrl.aluOp = legv8Pkg::aluAdd;
				ctrl.regWrite = 1'b1;
			end
			legv8Pkg::opSub: begin
				ctrl.aluOp = legv8Pkg::aluSub;
				ctrl.regWrite = 1'b1;
			end
			legv8Pkg::opAnd: begin
				ctrl.aluOp = legv8Pkg::aluAnd;
				ctrl.regWrite = 1'b1;
			end
			legv8Pkg::opOrr: begin
				ctrl.aluOp = legv8Pkg::aluOr;
				ctrl.regWrite = 1'b1;
			end
			legv8Pkg::opStur: begin
				// Store data comes from the rd field
				reg2Loc = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			legv8Pkg::opLdur: begin
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: begin
				// I-type opcodes are one bit shorter
				if (instr[31:22] == legv8Pkg::opAddi) begin
					ctrl.aluSrc = 1'b1;
					ctrl.aluOp = legv8Pkg::aluAdd;
					ctrl.regWrite = 1'b1;
				end else if (instr[31:22] == legv8Pkg::opSubi) begin
					ctrl.aluSrc = 1'b1;
					ctrl.aluOp = legv8Pkg::aluSub;
					ctrl.regWrite = 1'b1;
				end
			end
		endcase
	end

	// ALU immediates are unsigned, D-type offsets signed
	always_comb begin
		if (instr[31:22] == legv8Pkg::opAddi || instr[31:22] == legv8Pkg::opSubi) begin
			imm = {52'b0, instr[21:10]};
		end else if (opcode == legv8Pkg::opStur || opcode == legv8Pkg::opLdur) begin
			imm = {{55{instr[20]}}, instr[20:12]};
		end else begin
			imm = '0;
		end
	end

	assign readAddr2 = reg2Loc ? rd : rm;

	registerFile regFile (
		.clk(clk),
		.readAddr1(rn),
		.readAddr2(readAddr2),
		.writeAddr(wbRd),
		.writeEn(wbValid),
		.writeData(wbData),
		.readData1(readData1),
		.readData2(readData2)
	);

	////////////////////////////////////////////////////////////
	// Load-use hazard
	////////////////////////////////////////////////////////////

	assign stall = exMemRead && (exRd == rn || exRd == readAddr2);

	always_comb begin
		idEx.ctrl = stall ? '0 : ctrl;
		idEx.readData1 = readData1;
		idEx.readData2 = readData2;
		idEx.imm = imm;
		idEx.rd = rd;
		idEx.rn = rn;
		// The register actually read, so forwarding also covers store data
		idEx.rm = readAddr2;
	end

endmodule

`default_nettype wire

/* logic/executeStage.sv */
`default_nettype none
`timescale 1ns/100ps

module executeStage (
	input legv8Pkg::idExS idEx,
	input legv8Pkg::regAddrT memRd,
	input wire logic memRegWrite,
	input legv8Pkg::wordT memAluResult,
	input legv8Pkg::regAddrT wbRd,
	input wire logic wbValid,
	input legv8Pkg::wordT wbData,
	output legv8Pkg::exMemS exMem
);

	legv8Pkg::wordT opA;
	legv8Pkg::wordT opB;
	legv8Pkg::wordT aluB;
	legv8Pkg::wordT aluResult;

	// Writeback checked before memory stage
	function automatic legv8Pkg::wordT forwardSel(
		input legv8Pkg::regAddrT src,
		input legv8Pkg::wordT regVal,
		input legv8Pkg::regAddrT mRd,
		input logic mWrite,
		input legv8Pkg::wordT mVal,
		input legv8Pkg::regAddrT wRd,
		input logic wWrite,
		input legv8Pkg::wordT wVal
	);
		legv8Pkg::wordT sel;
		if (wWrite && wRd != legv8Pkg::zeroReg && wRd == src) begin
			sel = wVal;
		end else if (mWrite && mRd != legv8Pkg::zeroReg && mRd == src) begin
			sel = mVal;
		end else begin
			sel = regVal;
		end
		return sel;
	endfunction

	assign opA = forwardSel(idEx.rn, idEx.readData1, memRd, memRegWrite, memAluResult,
		wbRd, wbValid, wbData);
	assign opB = forwardSel(idEx.rm, idEx.readData2, memRd, memRegWrite, memAluResult,
		wbRd, wbValid, wbData);

	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : opB;

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////

	always_comb begin
		case (idEx.ctrl.aluOp)
			legv8Pkg::aluAdd: aluResult = opA + aluB;
			legv8Pkg::aluSub: aluResult = opA - aluB;
			legv8Pkg::aluAnd: aluResult = opA & aluB;
			legv8Pkg::aluOr: aluResult = opA | aluB;
			default: aluResult = '0;
		endcase
	end

	always_comb begin
		exMem.memRead = idEx.ctrl.memRead;
		exMem.memWrite = idEx.ctrl.memWrite;
		exMem.memToReg = idEx.ctrl.memToReg;
		exMem.regWrite = idEx.ctrl.regWrite;
		exMem.aluResult = aluResult;
		exMem.storeData = opB;
		exMem.rd = idEx.rd;
	end

endmodule

`default_nettype wire

/* logic/legv8Core.sv */
`default_nettype none
`timescale 1ns/100ps

module legv8Core #(
	parameter int pcWidth = 10
) (
	input wire logic clk,
	input wire logic rstN,
	output logic [pcWidth-1:0] instrAddr,
	input legv8Pkg::instrT instr,
	output legv8Pkg::wordT dataAddr,
	output legv8Pkg::wordT writeData,
	input legv8Pkg::wordT readData,
	output logic memRead,
	output logic memWrite
);

	logic [pcWidth-1:0] pc;
	logic stall;

	legv8Pkg::ifIdS ifIdD;
	legv8Pkg::ifIdS ifIdQ;
	legv8Pkg::idExS idExD;
	legv8Pkg::idExS idExQ;
	legv8Pkg::exMemS exMemD;
	legv8Pkg::exMemS exMemQ;
	legv8Pkg::memWbS memWbD;
	legv8Pkg::memWbS memWbQ;

	logic wbValid;
	legv8Pkg::regAddrT wbRd;
	legv8Pkg::wordT wbData;

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + pcWidth'(4);
		end
	end

	assign instrAddr = pc;
	assign ifIdD.instr = instr;

	// Held while decode waits on a load
	stageReg #(.payloadT(legv8Pkg::ifIdS)) ifIdReg (
		.clk(clk),
		.rstN(rstN),
		.hold(stall),
		.bubble(1'b0),
		.d(ifIdD),
		.q(ifIdQ)
	);

	decodeStage decode (
		.clk(clk),
		.ifId(ifIdQ),
		.exRd(idExQ.rd),
		.exMemRead(idExQ.ctrl.memRead),
		.wbValid(wbValid),
		.wbRd(wbRd),
		.wbData(wbData),
		.idEx(idExD),
		.stall(stall)
	);

	// Bubble into EX on a stall
	stageReg #(.payloadT(legv8Pkg::idExS)) idExReg (
		.clk(clk),
		.rstN(rstN),
		.hold(1'b0),
		.bubble(stall),
		.d(idExD),
		.q(idExQ)
	);

	executeStage execute (
		.idEx(idExQ),
		.memRd(exMemQ.rd),
		.memRegWrite(exMemQ.regWrite),
		.memAluResult(exMemQ.aluResult),
		.wbRd(wbRd),
		.wbValid(wbValid),
		.wbData(wbData),
		.exMem(exMemD)
	);

	stageReg #(.payloadT(legv8Pkg::exMemS)) exMemReg (
		.clk(clk),
		.rstN(rstN),
		.hold(1'b0),
		.bubble(1'b0),
		.d(exMemD),
		.q(exMemQ)
	);

	////////////////////////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////////////////////////

	assign dataAddr = exMemQ.aluResult;
	assign writeData = exMemQ.storeData;
	assign memRead = exMemQ.memRead;
	assign memWrite = exMemQ.memWrite;

	always_comb begin
		memWbD.regWrite = exMemQ.regWrite;
		memWbD.memToReg = exMemQ.memToReg;
		memWbD.loadData = readData;
		memWbD.aluResult = exMemQ.aluResult;
		memWbD.rd = exMemQ.rd;
	end

	stageReg #(.payloadT(legv8Pkg::memWbS)) memWbReg (
		.clk(clk),
		.rstN(rstN),
		.hold(1'b0),
		.bubble(1'b0),
		.d(memWbD),
		.q(memWbQ)
	);

	assign wbValid = memWbQ.regWrite;
	assign wbRd = memWbQ.rd;
	assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

endmodule

`default_nettype wire

/* logic/legv8Pkg.sv */
`default_nettype none

package legv8Pkg;

	////////////////////////////////////////////////////////////
	// Widths and register indices
	////////////////////////////////////////////////////////////

	parameter int xlen = 64;
	parameter int regAddrBits = 5;

	typedef logic [xlen-1:0] wordT;
	typedef logic [31:0] instrT;
	typedef logic [regAddrBits-1:0] regAddrT;

	// XZR
	parameter regAddrT zeroReg = 5'd31;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	// R-type, instr[31:21]
	parameter logic [10:0] opAdd = 11'b10001011000;
	parameter logic [10:0] opSub = 11'b11001011000;
	parameter logic [10:0] opAnd = 11'b10001010000;
	parameter logic [10:0] opOrr = 11'b10101010000;

	// D-type, instr[31:21]
	parameter logic [10:0] opStur = 11'b11111000000;
	parameter logic [10:0] opLdur = 11'b11111000010;

	// I-type, instr[31:22]
	parameter logic [9:0] opAddi = 10'b1001000100;
	parameter logic [9:0] opSubi = 10'b1101000100;

	typedef enum logic [1:0] {
		aluAdd = 2'b00,
		aluSub = 2'b01,
		aluAnd = 2'b10,
		aluOr  = 2'b11
	} aluOpE;

	////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////

	// All zero means no-op
	typedef struct packed {
		logic aluSrc;
		aluOpE aluOp;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
	} ctrlS;

	typedef struct packed {
		instrT instr;
	} ifIdS;

	typedef struct packed {
		ctrlS ctrl;
		wordT readData1;
		wordT readData2;
		wordT imm;
		regAddrT rd;
		regAddrT rn;
		regAddrT rm;
	} idExS;

	typedef struct packed {
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic regWrite;
		wordT aluResult;
		wordT storeData;
		regAddrT rd;
	} exMemS;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		wordT loadData;
		wordT aluResult;
		regAddrT rd;
	} memWbS;

endpackage

`default_nettype wire

/* logic/registerFile.sv */
`default_nettype none
`timescale 1ns/100ps

module registerFile (
	input wire logic clk,
	input legv8Pkg::regAddrT readAddr1,
	input legv8Pkg::regAddrT readAddr2,
	input legv8Pkg::regAddrT writeAddr,
	input wire logic writeEn,
	input legv8Pkg::wordT writeData,
	output legv8Pkg::wordT readData1,
	output legv8Pkg::wordT readData2
);

	legv8Pkg::wordT regs [32];

	// XZR is never stored
	always_ff @(posedge clk) begin
		if (writeEn && writeAddr != legv8Pkg::zeroReg) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Same-cycle writeback goes straight through to the read
	always_comb begin
		if (readAddr1 == legv8Pkg::zeroReg) begin
			readData1 = '0;
		end else if (writeEn && writeAddr == readAddr1) begin
			readData1 = writeData;
		end else begin
			readData1 = regs[readAddr1];
		end

		if (readAddr2 == legv8Pkg::zeroReg) begin
			readData2 = '0;
		end else if (writeEn && writeAddr == readAddr2) begin
			readData2 = writeData;
		end else begin
			readData2 = regs[readAddr2];
		end
	end

endmodule

`default_nettype wire

/* logic/stageReg.sv */
`default_nettype none
`timescale 1ns/100ps

module stageReg #(
	parameter type payloadT = logic
) (
	input wire logic clk,
	input wire logic rstN,
	input wire logic hold,
	input wire logic bubble,
	input payloadT d,
	output payloadT q
);

	// Hold wins over bubble
	always_ff @(posedge clk) begin
		if (!rstN) begin
			q <= '0;
		end else if (hold) begin
			q <= q;
		end else if (bubble) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

/* tb/legv8CoreTb.sv */
`default_nettype none
`timescale 1ns/100ps

module legv8CoreTb;

	logic clk;
	logic rstN;
	logic [9:0] instrAddr;
	legv8Pkg::instrT instr;
	legv8Pkg::wordT dataAddr;
	legv8Pkg::wordT writeData;
	legv8Pkg::wordT readData;
	logic memRead;
	logic memWrite;

	legv8Pkg::instrT imem [256];
	legv8Pkg::wordT dmem [32];
	legv8Pkg::wordT expAddr [512];
	legv8Pkg::wordT expData [512];
	int progLen;
	int expCount;
	int gotCount;
	int errors;
	int checks;
	int unsigned lcgState = 51125;

	legv8Core #(.pcWidth(10)) dut_i (
		.clk(clk),
		.rstN(rstN),
		.instrAddr(instrAddr),
		.instr(instr),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.readData(readData),
		.memRead(memRead),
		.memWrite(memWrite)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////

	assign instr = imem[instrAddr[9:2]];
	assign readData = memRead ? dmem[dataAddr[7:3]] : '0;

	always @(posedge clk) begin
		if (memWrite) begin
			dmem[dataAddr[7:3]] <= writeData;
		end
	end

	// Whole index folded in, top byte tagged per run
	task automatic fillDataMem(input int runId);
		int i;
		for (i = 0; i < 32; i++) begin
			dmem[i] = 64'h0123_4567_89AB_CDEF ^ (64'(i) * 64'h0001_0003_0007_000F)
				^ (64'(runId) << 56);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Program building
	////////////////////////////////////////////////////////////

	function automatic legv8Pkg::instrT rFormat(input logic [10:0] op, input int rm,
		input int rn, input int rd);
		return {op, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
	endfunction

	function automatic legv8Pkg::instrT iFormat(input logic [9:0] op, input int imm,
		input int rn, input int rd);
		return {op, 12'(imm), 5'(rn), 5'(rd)};
	endfunction

	// Loads and stores always use XZR as base
	function automatic legv8Pkg::instrT dFormat(input logic [10:0] op, input int off,
		input int rt);
		return {op, 9'(off), 2'b00, legv8Pkg::zeroReg, 5'(rt)};
	endfunction

	function automatic int unsigned nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState >> 8;
	endfunction

	task automatic emit(input legv8Pkg::instrT ins);
		imem[progLen] = ins;
		progLen++;
	endtask

	task automatic clearProgram();
		int i;
		for (i = 0; i < 256; i++) begin
			imem[i] = '0;
		end
		progLen = 0;
	endtask

	task automatic loadDirected();
		clearProgram();
		emit(iFormat(legv8Pkg::opAddi, 100, legv8Pkg::zeroReg, 1));
		emit(iFormat(legv8Pkg::opAddi, 7, legv8Pkg::zeroReg, 2));
		// Dependency chain at distances one to three
		emit(rFormat(legv8Pkg::opAdd, 2, 1, 3));
		emit(rFormat(legv8Pkg::opSub, 1, 3, 4));
		emit(rFormat(legv8Pkg::opAnd, 3, 4, 5));
		emit(rFormat(legv8Pkg::opOrr, 3, 5, 6));
		emit(iFormat(legv8Pkg::opSubi, 3, 6, 7));
		emit(dFormat(legv8Pkg::opStur, 32, 7));
		emit(dFormat(legv8Pkg::opStur, 0, 3));
		emit(dFormat(legv8Pkg::opStur, 8, 4));
		emit(dFormat(legv8Pkg::opStur, 16, 5));
		emit(dFormat(legv8Pkg::opStur, 24, 6));
		// Load-use pairs
		emit(dFormat(legv8Pkg::opLdur, 8, 8));
		emit(rFormat(legv8Pkg::opAdd, 1, 8, 9));
		emit(dFormat(legv8Pkg::opStur, 40, 9));
		emit(dFormat(legv8Pkg::opLdur, 200, 10));
		emit(dFormat(legv8Pkg::opStur, 48, 10));
		// XZR as destination and source
		emit(iFormat(legv8Pkg::opAddi, 5, 1, legv8Pkg::zeroReg));
		emit(rFormat(legv8Pkg::opAdd, 2, legv8Pkg::zeroReg, 11));
		emit(dFormat(legv8Pkg::opStur, 56, 11));
		emit(dFormat(legv8Pkg::opStur, 64, legv8Pkg::zeroReg));
		emit(dFormat(legv8Pkg::opLdur, 0, legv8Pkg::zeroReg));
		emit(rFormat(legv8Pkg::opOrr, legv8Pkg::zeroReg, legv8Pkg::zeroReg, 12));
		emit(dFormat(legv8Pkg::opStur, 72, 12));
		emit(rFormat(legv8Pkg::opSub, 1, 2, 13));
		emit(dFormat(legv8Pkg::opStur, 80, 13));
	endtask

	// 31 inits, 138 random, 31 closing stores
	task automatic loadRandom();
		int i;
		int kind;
		int rd;
		int prevRd;
		clearProgram();
		for (i = 0; i < 31; i++) begin
			emit(iFormat(legv8Pkg::opAddi, nextRand() % 4096, legv8Pkg::zeroReg, i));
		end
		prevRd = 30;
		for (i = 0; i < 138; i++) begin
			kind = nextRand() % 8;
			rd = nextRand() % 32;
			// Same rd twice in a row would hit both forwarding stages
			if (kind != 7 && rd == prevRd) begin
				rd = (rd + 1) % 32;
			end
			case (kind)
				0: emit(rFormat(legv8Pkg::opAdd, nextRand() % 32, nextRand() % 32, rd));
				1: emit(rFormat(legv8Pkg::opSub, nextRand() % 32, nextRand() % 32, rd));
				2: emit(rFormat(legv8Pkg::opAnd, nextRand() % 32, nextRand() % 32, rd));
				3: emit(rFormat(legv8Pkg::opOrr, nextRand() % 32, nextRand() % 32, rd));
				4: emit(iFormat(legv8Pkg::opAddi, nextRand() % 4096, nextRand() % 32, rd));
				5: emit(iFormat(legv8Pkg::opSubi, nextRand() % 4096, nextRand() % 32, rd));
				6: emit(dFormat(legv8Pkg::opLdur, (nextRand() % 32) * 8, rd));
				default: emit(dFormat(legv8Pkg::opStur, (nextRand() % 32) * 8, rd));
			endcase
			prevRd = (kind == 7) ? -1 : rd;
		end
		for (i = 0; i < 31; i++) begin
			emit(dFormat(legv8Pkg::opStur, i * 8, i));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Sequential ISA model, fills the expected store list
	////////////////////////////////////////////////////////////

	function automatic int refModel();
		legv8Pkg::wordT regs [32];
		legv8Pkg::wordT mem [32];
		legv8Pkg::wordT a;
		legv8Pkg::wordT b;
		legv8Pkg::wordT res;
		legv8Pkg::wordT addr;
		legv8Pkg::instrT ins;
		logic wr;
		int rd;
		int i;
		int n;
		n = 0;
		for (i = 0; i < 32; i++) begin
			regs[i] = '0;
			mem[i] = dmem[i];
		end
		for (i = 0; i < progLen; i++) begin
			ins = imem[i];
			rd = ins[4:0];
			a = regs[ins[9:5]];
			b = regs[ins[20:16]];
			addr = a + {{55{ins[20]}}, ins[20:12]};
			res = '0;
			wr = 1'b1;
			case (ins[31:21])
				legv8Pkg::opAdd: res = a + b;
				legv8Pkg::opSub: res = a - b;
				legv8Pkg::opAnd: res = a & b;
				legv8Pkg::opOrr: res = a | b;
				legv8Pkg::opLdur: res = mem[addr[7:3]];
				legv8Pkg::opStur: begin
					wr = 1'b0;
					mem[addr[7:3]] = regs[rd];
					expAddr[n] = addr;
					expData[n] = regs[rd];
					n++;
				end
				default: begin
					if (ins[31:22] == legv8Pkg::opAddi) begin
						res = a + {52'd0, ins[21:10]};
					end else if (ins[31:22] == legv8Pkg::opSubi) begin
						res = a - {52'd0, ins[21:10]};
					end else begin
						wr = 1'b0;
					end
				end
			endcase
			if (wr && rd != legv8Pkg::zeroReg) begin
				regs[rd] = res;
			end
		end
		return n;
	endfunction

	// Store stream compared in order
	always @(negedge clk) begin
		if (rstN && memWrite) begin
			checks++;
			if (gotCount < expCount) begin
				assert (dataAddr == expAddr[gotCount] && writeData == expData[gotCount]) else begin
					errors++;
					$display("Error at %0t: store %0d wrote %h to %h, expected %h to %h",
						$time, gotCount, writeData, dataAddr, expData[gotCount],
						expAddr[gotCount]);
				end
			end else begin
				errors++;
				$display("Error at %0t: extra store of %h to %h", $time, writeData, dataAddr);
			end
			gotCount++;
		end
	end

	task automatic runProgram(input int runId, input int limit);
		int i;
		int cycles;
		@(posedge clk);
		rstN <= 1'b0;
		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			if (i == 2) begin
				if (runId == 0) begin
					loadDirected();
				end else begin
					loadRandom();
				end
				fillDataMem(runId);
				gotCount = 0;
				expCount = refModel();
			end
			if (i > 0) begin
				checks++;
				assert (!memRead && !memWrite) else begin
					errors++;
					$display("Error at %0t: memory strobe active during reset", $time);
				end
			end
			@(posedge clk);
		end
		rstN <= 1'b1;
		for (i = 0; i < 3; i++) begin
			@(negedge clk);
			checks++;
			assert (!memRead && !memWrite && (i > 0 || instrAddr == 0)) else begin
				errors++;
				$display("Error at %0t: cycle %0d after reset, instrAddr %0d, strobes %b%b",
					$time, i, instrAddr, memRead, memWrite);
			end
		end
		cycles = 3;
		while (gotCount < expCount && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (gotCount < expCount) begin
			errors++;
			$display("Timed out after %0d cycles with %0d of %0d stores seen",
				cycles, gotCount, expCount);
		end
		// Window for late extra stores
		repeat (10) @(negedge clk);
		checks++;
		assert (gotCount == expCount) else begin
			errors++;
			$display("Error at %0t: %0d stores seen, expected %0d", $time, gotCount, expCount);
		end
	endtask

	initial begin
		rstN = 1'b0;
		errors = 0;
		checks = 0;
		gotCount = 0;
		expCount = 0;
		clearProgram();
		fillDataMem(0);
		runProgram(0, 100);
		runProgram(1, 600);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
